// ==== list.f ====
rtl/bpu_pkg.sv
rtl/ftb_lookup_if.sv
rtl/ftq_enq_if.sv
rtl/ftb.sv
rtl/bpu.sv
rtl/ftq.sv
rtl/frontend_top.sv
verif/frontend_properties.sv
verif/frontend_tb.sv

// ==== rtl/bpu.sv ====
module bpu (
    input  logic                i_squash_vld,
    input  bpu_pkg::addr_t      i_squash_pc,
    input  logic                clk,
    input  logic                rst,
    input  logic                i_update_vld,
    input  bpu_pkg::addr_t      i_update_pc,
    input  bpu_pkg::ftb_entry_t i_update_entry,
    output logic                o_update_done,
    ftb_lookup_if.bpu_mp        ftb,
    ftq_enq_if.bpu_mp           enq
);
    import bpu_pkg::*;

    // s0 is base_pc, s1 and s2 follow the FTB pipeline
    addr_t base_pc;
    addr_t s1_pc;
    addr_t s2_pc;
    logic  s1_vld;
    logic  s2_vld;
    logic  s2_hit;

    logic  advance;
    logic  s2_taken;
    addr_t s2_seq_pc;
    addr_t s2_end;
    addr_t s2_npc;
    logic  s2_redirect;
    addr_t rewind_pc;

    // whole pipeline holds while the queue is full
    assign advance = enq.enq_rdy;

    assign ftb.lookup_pc = base_pc;
    assign ftb.lookup_en = advance;

    // update request goes straight to the FTB
    assign ftb.upd_vld   = i_update_vld;
    assign ftb.upd_pc    = i_update_pc;
    assign ftb.upd_entry = i_update_entry;
    assign o_update_done = ftb.upd_done;

    assign s2_seq_pc = s2_pc + addr_t'(FETCH_BYTES);
    assign s2_taken  = s2_hit && (ftb.s2_entry.ctr >= ctr_t'(2));
    assign s2_end    = s2_hit ? calc_fallthru(s2_pc, ftb.s2_entry) : s2_seq_pc;
    assign s2_npc    = s2_hit ? calc_npc(s2_pc, s2_taken, ftb.s2_entry) : s2_seq_pc;

    // hold the block back during an update, it is replayed after the rewind
    assign enq.enq_vld = s2_vld && !i_update_vld;

    // redirect only when the block does not continue into s1
    assign s2_redirect = enq.enq_vld && enq.enq_rdy && (s2_npc != s2_seq_pc);

    // oldest start address still in flight
    assign rewind_pc = s2_vld ? s2_pc : (s1_vld ? s1_pc : base_pc);

    assign enq.enq_entry = '{
        start_addr : s2_pc,
        end_addr   : s2_end,
        taken      : s2_taken,
        target     : s2_hit ? ftb.s2_entry.target : s2_end,
        hit        : s2_hit,
        br_type    : s2_hit ? ftb.s2_entry.br_type : br_none,
        ctr        : s2_hit ? ftb.s2_entry.ctr : ctr_t'(1)
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            base_pc <= INIT_PC;
            s1_vld  <= 1'b0;
            s2_vld  <= 1'b0;
        end else if (i_squash_vld) begin
            base_pc <= i_squash_pc;
            s1_vld  <= 1'b0;
            s2_vld  <= 1'b0;
        end else if (i_update_vld) begin
            base_pc <= rewind_pc;
            s1_vld  <= 1'b0;
            s2_vld  <= 1'b0;
        end else if (s2_redirect) begin
            // s2 is accepted, younger work is dropped
            base_pc <= s2_npc;
            s1_vld  <= 1'b0;
            s2_vld  <= 1'b0;
        end else if (advance) begin
            base_pc <= base_pc + addr_t'(FETCH_BYTES);
            s1_vld  <= 1'b1;
            s2_vld  <= s1_vld;
        end
    end

    // stage addresses shift in step with the FTB registers
    always_ff @(posedge clk) begin
        if (advance) begin
            s1_pc  <= base_pc;
            s2_pc  <= s1_pc;
            s2_hit <= ftb.s1_hit;
        end
    end

endmodule

// ==== rtl/bpu_pkg.sv ====
package bpu_pkg;

    // address and block geometry
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  offset_t;
    typedef logic [23:0] tag_t;

    localparam int    FETCH_BYTES = 16;
    localparam int    FTB_ENTRIES = 16;
    localparam int    FTB_IDX_W   = 4;
    localparam int    FTQ_DEPTH   = 8;
    localparam addr_t INIT_PC     = 32'h0000_1000;

    // 2-bit saturating counter, taken when >= 2
    typedef logic [1:0] ctr_t;

    typedef enum logic [2:0] {
        br_none,
        br_cond,
        br_jump,
        br_call,
        br_ret
    } br_type_t;

    // fallthru is 5 bits so a full 16-byte block fits
    typedef struct packed {
        logic [4:0] fallthru;
        br_type_t   br_type;
        addr_t      target;
        ctr_t       ctr;
    } ftb_entry_t;

    // one predicted fetch block, range is [start, end)
    typedef struct packed {
        addr_t    start_addr;
        addr_t    end_addr;
        logic     taken;
        addr_t    target;
        logic     hit;
        br_type_t br_type;
        ctr_t     ctr;
    } ftq_entry_t;

    function automatic addr_t calc_fallthru(addr_t start, ftb_entry_t entry);
        return start + addr_t'(entry.fallthru);
    endfunction

    function automatic addr_t calc_npc(addr_t start, logic taken, ftb_entry_t entry);
        addr_t npc;
        if (taken) begin
            npc = entry.target;
        end else begin
            npc = calc_fallthru(start, entry);
        end
        return npc;
    endfunction

endpackage

// ==== rtl/frontend_top.sv ====
module frontend_top (
    input  logic                clk,
    input  logic                rst,

    // backend redirect
    input  logic                i_squash_vld,
    input  bpu_pkg::addr_t      i_squash_pc,

    // FTB write from the backend
    input  logic                i_update_vld,
    input  bpu_pkg::addr_t      i_update_pc,
    input  bpu_pkg::ftb_entry_t i_update_entry,
    output logic                o_update_done,

    // predicted blocks toward fetch
    output logic                o_fetch_vld,
    output bpu_pkg::ftq_entry_t o_fetch_entry,
    input  logic                i_fetch_rdy
);

    ftb_lookup_if ftb_lk ();
    ftq_enq_if    ftq_enq ();

    bpu u_bpu (
        .clk            (clk),
        .rst            (rst),
        .i_squash_vld   (i_squash_vld),
        .i_squash_pc    (i_squash_pc),
        .i_update_vld   (i_update_vld),
        .i_update_pc    (i_update_pc),
        .i_update_entry (i_update_entry),
        .o_update_done  (o_update_done),
        .ftb            (ftb_lk.bpu_mp),
        .enq            (ftq_enq.bpu_mp)
    );

    ftb u_ftb (
        .clk (clk),
        .rst (rst),
        .lk  (ftb_lk.ftb_mp)
    );

    // squash also drops everything already queued
    ftq u_ftq (
        .clk           (clk),
        .rst           (rst),
        .i_flush       (i_squash_vld),
        .enq           (ftq_enq.ftq_mp),
        .o_fetch_vld   (o_fetch_vld),
        .o_fetch_entry (o_fetch_entry),
        .i_fetch_rdy   (i_fetch_rdy)
    );

endmodule

// ==== rtl/ftb.sv ====
module ftb (
    input  logic         clk,
    input  logic         rst,
    ftb_lookup_if.ftb_mp lk
);
    import bpu_pkg::*;

    localparam int OFF_W = $bits(offset_t);
    localparam int TAG_W = $bits(tag_t);
    localparam int PC_W  = $bits(addr_t);

    // direct-mapped storage, one entry per set
    logic [FTB_ENTRIES-1:0] valid_q;
    tag_t                   tag_mem   [FTB_ENTRIES];
    ftb_entry_t             entry_mem [FTB_ENTRIES];

    logic [FTB_IDX_W-1:0] lk_idx;
    tag_t                 lk_tag;
    logic [FTB_IDX_W-1:0] upd_idx;
    tag_t                 upd_tag;

    // stage one registers
    logic [FTB_IDX_W-1:0] s1_idx;
    tag_t                 s1_tag;

    assign lk_idx  = lk.lookup_pc[OFF_W +: FTB_IDX_W];
    assign lk_tag  = lk.lookup_pc[PC_W-1 -: TAG_W];
    assign upd_idx = lk.upd_pc[OFF_W +: FTB_IDX_W];
    assign upd_tag = lk.upd_pc[PC_W-1 -: TAG_W];

    // set read and tag compare happen in stage one
    assign lk.s1_hit = valid_q[s1_idx] && (tag_mem[s1_idx] == s1_tag);

    always_ff @(posedge clk) begin
        if (lk.lookup_en) begin
            s1_idx      <= lk_idx;
            s1_tag      <= lk_tag;
            lk.s2_entry <= entry_mem[s1_idx];
        end
    end

    // whole set is overwritten by an update
    always_ff @(posedge clk) begin
        if (lk.upd_vld) begin
            tag_mem[upd_idx]   <= upd_tag;
            entry_mem[upd_idx] <= lk.upd_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q     <= '0;
            lk.upd_done <= 1'b0;
        end else begin
            if (lk.upd_vld) begin
                valid_q[upd_idx] <= 1'b1;
            end
            // completion one cycle after the request
            lk.upd_done <= lk.upd_vld;
        end
    end

endmodule

// ==== rtl/ftb_lookup_if.sv ====
interface ftb_lookup_if;
    import bpu_pkg::*;

    // lookup path
    addr_t      lookup_pc;
    logic       lookup_en;
    logic       s1_hit;
    ftb_entry_t s2_entry;

    // update path
    logic       upd_vld;
    addr_t      upd_pc;
    ftb_entry_t upd_entry;
    logic       upd_done;

    modport bpu_mp (
        output lookup_pc, lookup_en, upd_vld, upd_pc, upd_entry,
        input  s1_hit, s2_entry, upd_done
    );

    modport ftb_mp (
        input  lookup_pc, lookup_en, upd_vld, upd_pc, upd_entry,
        output s1_hit, s2_entry, upd_done
    );

endinterface

// ==== rtl/ftq.sv ====
module ftq (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_flush,
    ftq_enq_if.ftq_mp           enq,
    output logic                o_fetch_vld,
    output bpu_pkg::ftq_entry_t o_fetch_entry,
    input  logic                i_fetch_rdy
);
    import bpu_pkg::*;

    localparam int PTR_W = $clog2(FTQ_DEPTH);

    ftq_entry_t mem [FTQ_DEPTH];

    // extra msb is the wrap bit
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;

    logic full;
    logic empty;
    logic do_enq;
    logic do_deq;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W])
                && (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign enq.enq_rdy = !full;

    // flush wins over an enqueue in the same cycle
    assign do_enq = enq.enq_vld && !full && !i_flush;
    assign do_deq = o_fetch_vld && i_fetch_rdy;

    assign o_fetch_vld   = !empty;
    assign o_fetch_entry = mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr[PTR_W-1:0]] <= enq.enq_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/ftq_enq_if.sv ====
interface ftq_enq_if;
    import bpu_pkg::*;

    logic       enq_vld;
    ftq_entry_t enq_entry;
    // high while the queue has room
    logic       enq_rdy;

    modport bpu_mp (
        output enq_vld, enq_entry,
        input  enq_rdy
    );

    modport ftq_mp (
        input  enq_vld, enq_entry,
        output enq_rdy
    );

endinterface

// ==== verif/frontend_properties.sv ====
module frontend_properties (
    input logic                clk,
    input logic                rst,
    input logic                i_squash_vld,
    input logic                i_fetch_rdy,
    input logic                o_fetch_vld,
    input logic                o_update_done,
    input bpu_pkg::ftq_entry_t o_fetch_entry
);

    // number of assertion failures so far
    int fail_cnt = 0;

    reset_quiet: assert property (@(posedge clk) rst |=> !o_fetch_vld && !o_update_done)
        else begin
            $error("fetch valid or update done high in the cycle after reset");
            fail_cnt++;
        end

    done_single_pulse: assert property (@(posedge clk) disable iff (rst)
        o_update_done |=> !o_update_done)
        else begin
            $error("update done held high for two cycles");
            fail_cnt++;
        end

    // a stalled block must be held until taken or squashed
    fetch_held_stable: assert property (@(posedge clk) disable iff (rst)
        (o_fetch_vld && !i_fetch_rdy && !i_squash_vld) |=> o_fetch_vld && $stable(o_fetch_entry))
        else begin
            $error("fetch block changed while stalled");
            fail_cnt++;
        end

endmodule

bind frontend_top frontend_properties u_props (.*);

// ==== verif/frontend_tb.sv ====
module frontend_tb;
    import bpu_pkg::*;

    logic       clk;
    logic       rst;
    logic       i_squash_vld;
    addr_t      i_squash_pc;
    logic       i_update_vld;
    addr_t      i_update_pc;
    ftb_entry_t i_update_entry;
    logic       o_update_done;
    logic       o_fetch_vld;
    ftq_entry_t o_fetch_entry;
    logic       i_fetch_rdy;

    // reference model
    logic [15:0]            lfsr;
    logic [FTB_ENTRIES-1:0] m_vld;
    tag_t                   m_tag [FTB_ENTRIES];
    ftb_entry_t             m_ent [FTB_ENTRIES];
    addr_t                  exp_pc;
    ftq_entry_t             exp_blk;
    int                     upd_pending;
    int                     blk_cnt;
    int                     hit_cnt;

    frontend_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fibonacci LFSR x^16+x^14+x^13+x^11+1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic addr_t pool_addr(input logic [31:0] k);
        return INIT_PC + k * 32'h30;
    endfunction

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_equal(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // expected block for a start address with index pc[7:4] and tag pc[31:8]
    function automatic ftq_entry_t predict(input addr_t pc);
        ftb_entry_t e;
        addr_t      seq;
        e = m_ent[pc[7:4]];
        seq = pc + addr_t'(FETCH_BYTES);
        if (m_vld[pc[7:4]] && m_tag[pc[7:4]] == pc[31:8]) begin
            return '{pc, pc + addr_t'(e.fallthru), e.ctr >= 2'd2, e.target, 1'b1,
                     e.br_type, e.ctr};
        end
        return '{pc, seq, 1'b0, seq, 1'b0, br_none, 2'd1};
    endfunction

    // covers the queue plus s2, s1 and base pc
    function automatic logic set_in_path(input addr_t pc, input logic [3:0] idx);
        ftq_entry_t e;
        for (int i = 0; i < FTQ_DEPTH + 4; i++) begin
            if (pc[7:4] == idx) begin
                return 1'b1;
            end
            e = predict(pc);
            pc = e.taken ? e.target : e.end_addr;
        end
        return 1'b0;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            exp_pc = INIT_PC;
        end else begin
            if (DUT.u_props.fail_cnt != 0) begin
                $display("an assertion bound to frontend_top failed");
                abort_run();
            end
            if (o_update_done) begin
                if (upd_pending == 0) begin
                    $display("o_update_done pulsed with no update outstanding");
                    abort_run();
                end
                upd_pending--;
            end
            if (o_fetch_vld && i_fetch_rdy) begin
                exp_blk = predict(exp_pc);
                check_equal("fetch block", o_fetch_entry, exp_blk);
                exp_pc = exp_blk.taken ? exp_blk.target : exp_blk.end_addr;
                blk_cnt++;
                hit_cnt += int'(exp_blk.hit);
            end
            if (i_squash_vld) begin
                exp_pc = i_squash_pc;
            end
        end
    end

    initial begin
        addr_t      pc;
        ftb_entry_t ent;
        int         phase;
        int         upd_wait;
        lfsr = 16'd7034;
        m_vld = '0;
        exp_pc = INIT_PC;
        upd_pending = 0;
        upd_wait = 0;
        blk_cnt = 0;
        hit_cnt = 0;
        rst = 1'b1;
        i_squash_vld = 1'b0;
        i_squash_pc = '0;
        i_update_vld = 1'b0;
        i_update_pc = '0;
        i_update_entry = '0;
        i_fetch_rdy = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        // 40-cycle phases of free run, updates, squashes, back-pressure and idle
        for (int c = 0; c < 1200; c++) begin
            @(negedge clk);
            phase = (c / 40) % 5;
            i_squash_vld = 1'b0;
            i_update_vld = 1'b0;
            case (phase)
                1: i_fetch_rdy = take_bits(1) != 0;
                3: i_fetch_rdy = take_bits(2) == 0;
                4: i_fetch_rdy = 1'b0;
                default: i_fetch_rdy = 1'b1;
            endcase
            if (upd_pending != 0) begin
                upd_wait++;
                if (upd_wait > 4) begin
                    $display("no o_update_done pulse within 4 cycles of an update");
                    abort_run();
                end
            end else if (phase == 1 && c % 6 == 0) begin
                pc = pool_addr(take_bits(3));
                // skip sets that blocks already predicted may depend on
                if (!set_in_path(exp_pc, pc[7:4])) begin
                    ent.fallthru = 5'(take_bits(4)) + 5'd1;
                    ent.br_type = br_type_t'(3'(take_bits(3) % 5));
                    ent.target = pool_addr(take_bits(3));
                    ent.ctr = ctr_t'(take_bits(2));
                    i_update_vld = 1'b1;
                    i_update_pc = pc;
                    i_update_entry = ent;
                    m_vld[pc[7:4]] = 1'b1;
                    m_tag[pc[7:4]] = pc[31:8];
                    m_ent[pc[7:4]] = ent;
                    upd_pending++;
                    upd_wait = 0;
                end
            end else if (phase == 2 && c % 10 == 0) begin
                i_squash_vld = 1'b1;
                i_squash_pc = pool_addr(take_bits(3));
            end
        end
        @(negedge clk);
        if (DUT.u_props.fail_cnt != 0) begin
            $display("an assertion bound to frontend_top failed");
            abort_run();
        end else if (blk_cnt > 200 && hit_cnt > 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("too few blocks (%0d) or no FTB hit (%0d) in the run", blk_cnt, hit_cnt);
            abort_run();
        end
    end

endmodule
